// ==== build.f ====
+incdir+hdl
hdl/dma_pkg.sv
hdl/capture_buffer.sv
hdl/beat_packer.sv
hdl/burst_writer.sv
hdl/capture_dma_top.sv
tests/axi_mem_model.sv
tests/capture_dma_tb.sv

// ==== Makefile ====
# Verilator flow for the capture DMA testbench

SIM := obj_dir/capture_dma_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): build.f hdl/*.sv hdl/*.svh tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module capture_dma_tb -Mdir obj_dir -o capture_dma_sim

# The simulator output goes to sim.log and the result is read from it
run: compile
	./$(SIM) | tee sim.log
	grep -q "^Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/capture_dma_tb.sv ====
// Capture DMA testbench with random stream stimulus, a window model and AXI write checks
`default_nettype none
`include "dma_defines.svh"

module capture_dma_tb;

    import dma_pkg::*;

    typedef logic [`DMA_ADDR_W-1:0] addr_t;
    typedef logic [`DMA_BUF_AW:0]   count_t;

    // Three captures of about 6000 cycles each for the input phase and a stall-heavy drain
    localparam int MAX_CYCLES    = 3 * 6000 + 2000;
    localparam int BURST_SAMPLES = 32;

    logic                    axi_out;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_ready;
    sample_t                 in_sample;
    logic                    trigger;
    count_t                  packet_length;
    count_t                  trigger_point;
    addr_t                   dma_base_addr;
    logic                    awvalid;
    logic                    awready;
    addr_t                   awaddr;
    logic [7:0]              awlen;
    logic [2:0]              awsize;
    logic [1:0]              awburst;
    logic [`DMA_ID_W-1:0]    awid;
    logic                    wvalid;
    logic                    wready;
    logic [`DMA_BEAT_W-1:0]  wdata;
    logic [`DMA_BEAT_W/8-1:0] wstrb;
    logic                    wlast;
    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;
    logic                    dma_done;
    logic                    dma_error;
    logic                    err_en;
    addr_t                   err_addr;

    // Reference model state that the monitor owns
    sample_t     hist [$];
    bit          armed = 1'b1;
    bit          closed = 1'b0;
    bit          reopen = 1'b0;
    bit          b_prev = 1'b0;
    int          trig_idx = 0;
    int          aw_count = 0;
    int          w_count = 0;
    int          b_count = 0;
    int          live_cycles = 0;
    int          errors = 0;
    int          captures_done = 0;
    int          beats_checked = 0;
    int          cycles = 0;
    logic [31:0] next_data = '0;

    capture_dma_top uut (.*);

    axi_mem_model mem (
        .axi_out  (axi_out),
        .rst_n    (rst_n),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wlast    (wlast),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .err_en   (err_en),
        .err_addr (err_addr)
    );

    initial begin
        axi_out = 1'b0;
        forever #10 axi_out = ~axi_out;
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        errors++;
        $display("FAIL %s expected %0h actual %0h", name, exp, act);
    endtask

    task automatic record_sample();
        hist.push_back(in_sample);
        if (trigger && armed) begin
            armed = 1'b0;
            trig_idx = hist.size() - 1;
        end
        // Last window sample is trigger_point back from the trigger plus packet_length
        if (!armed && !closed && (hist.size() - 1 == trig_idx - int'(trigger_point)
                                  + int'(packet_length) - 1)) begin
            closed = 1'b1;
        end
    endtask

    task automatic verify_window();
        int    start;
        addr_t a;
        beat_t exp_beat;
        start = trig_idx - int'(trigger_point);
        for (int j = 0; j < int'(packet_length) / 2; j++) begin
            a = dma_base_addr + addr_t'(16 * j);
            exp_beat = '{hi: hist[start + 2 * j + 1], lo: hist[start + 2 * j]};
            assert (mem.holds(a)) else begin
                errors++;
                $display("ERROR beat %0d at address %0h was never written", j, a);
            end
            if (mem.holds(a)) begin
                assert (mem.peek(a) == exp_beat)
                    else report_mismatch("beat_data", exp_beat, mem.peek(a));
                beats_checked++;
            end
        end
    endtask

    task automatic finish_capture();
        int bursts;
        bursts = int'(packet_length) / BURST_SAMPLES;
        assert (aw_count == bursts) else report_mismatch("aw_burst_count", bursts, aw_count);
        assert (b_count == bursts) else report_mismatch("b_burst_count", bursts, b_count);
        assert (w_count == bursts * 16) else report_mismatch("w_beat_count", bursts * 16, w_count);
        assert (dma_error == err_en) else report_mismatch("dma_error", err_en, dma_error);
        verify_window();
        aw_count = 0;
        w_count = 0;
        b_count = 0;
        closed = 1'b0;
        reopen = 1'b1;
        armed = 1'b1;
        captures_done++;
    endtask

    always @(posedge axi_out) begin
        if (!rst_n) begin
            live_cycles = 0;
            assert ({awvalid, wvalid, dma_done, dma_error} == 4'b0000)
                else report_mismatch("reset_outputs", 0,
                                     {awvalid, wvalid, dma_done, dma_error});
        end else begin
            live_cycles++;
            if (live_cycles == 1) begin
                assert (!in_ready) else report_mismatch("in_ready_reset", 0, in_ready);
            end else if (live_cycles == 2) begin
                assert (in_ready) else report_mismatch("in_ready_armed", 1, in_ready);
            end
            if (reopen) begin
                assert (in_ready) else report_mismatch("in_ready_rearm", 1, in_ready);
                reopen = 1'b0;
            end
            if (closed) begin
                assert (!in_ready) else report_mismatch("in_ready_drain", 0, in_ready);
            end
            if (in_valid && in_ready) begin
                record_sample();
            end
            if (awvalid && awready) begin
                assert (awlen == 8'd15) else report_mismatch("awlen", 15, awlen);
                assert (awaddr == dma_base_addr + addr_t'(256 * aw_count))
                    else report_mismatch("awaddr", dma_base_addr + addr_t'(256 * aw_count), awaddr);
                assert ({awsize, awburst, awid} == {3'd4, 2'b01, 2'b00})
                    else report_mismatch("aw_fixed", {3'd4, 2'b01, 2'b00}, {awsize, awburst, awid});
                aw_count++;
            end
            if (wvalid && wready) begin
                assert (wlast == ((w_count % 16) == 15))
                    else report_mismatch("wlast", (w_count % 16) == 15, wlast);
                assert (&wstrb) else report_mismatch("wstrb", {(`DMA_BEAT_W / 8){1'b1}}, wstrb);
                w_count++;
            end
            if (bvalid && bready) begin
                b_count++;
            end
            if (dma_done) begin
                // Completion follows the final write response by exactly one cycle
                assert (b_prev) else report_mismatch("done_after_b", 1, b_prev);
                finish_capture();
            end
            b_prev = bvalid && bready;
        end
    end

    // Samples go out on falling edges, where in_ready is stable until the next rising edge
    task automatic run_capture(input int tp, input int len, input addr_t base, input bit inject);
        int pre_need;
        int pre_sent;
        int post_sent;
        int done_seen;
        bit fired;
        pre_need = tp + int'($urandom % 8);
        pre_sent = 0;
        post_sent = 0;
        fired = 1'b0;
        done_seen = captures_done;
        @(negedge axi_out);
        trigger_point = count_t'(tp);
        packet_length = count_t'(len);
        dma_base_addr = base;
        err_en = inject;
        err_addr = base + addr_t'(3 * 256);
        while (!fired || (post_sent < len - tp - 1)) begin
            @(negedge axi_out);
            in_valid = ($urandom % 4) != 0;
            in_sample = '{user: 16'($urandom), dest: 16'($urandom), data: next_data};
            trigger = in_valid && in_ready && !fired && (pre_sent >= pre_need);
            if (in_valid && in_ready) begin
                next_data++;
                if (trigger) begin
                    fired = 1'b1;
                end else if (fired) begin
                    post_sent++;
                end else begin
                    pre_sent++;
                end
            end
        end
        // Keep offering samples during the drain so a leak past in_ready shows up
        while (captures_done == done_seen) begin
            @(negedge axi_out);
            in_valid = ($urandom % 2) != 0;
            trigger = 1'b0;
            in_sample = '{user: 16'($urandom), dest: 16'($urandom), data: next_data};
            if (in_valid && in_ready) begin
                next_data++;
            end
        end
    endtask

    initial begin
        void'($urandom(14949));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_sample = '0;
        trigger = 1'b0;
        packet_length = count_t'(256);
        trigger_point = '0;
        dma_base_addr = '0;
        err_en = 1'b0;
        err_addr = '0;
        repeat (8) @(posedge axi_out);
        @(negedge axi_out);
        rst_n = 1'b1;
        repeat (3) @(negedge axi_out);
        run_capture(5, 256, addr_t'(49'h3f00_0000), 1'b0);
        run_capture(40, 256, addr_t'(49'h3f10_0000), 1'b0);
        run_capture(17, 256, addr_t'(49'h3f20_0000), 1'b1);
        repeat (4) @(negedge axi_out);
        $display("Summary: %0d errors, %0d captures, %0d beats checked",
                 errors, captures_done, beats_checked);
        if ((errors == 0) && (captures_done == 3)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge axi_out);
            cycles++;
        end
        $display("ERROR run stopped after %0d cycles before all captures finished", cycles);
        $display("Summary: %0d errors, %0d captures, %0d beats checked",
                 errors, captures_done, beats_checked);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/axi_mem_model.sv ====
// AXI4 write slave model with random stalls, sparse beat storage and SLVERR injection
`default_nettype none
`include "dma_defines.svh"

module axi_mem_model #(
    parameter int STALL_PCT = 40
) (
    input  wire                       axi_out,
    input  wire                       rst_n,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire [`DMA_ADDR_W-1:0]     awaddr,
    input  wire                       wvalid,
    output logic                      wready,
    input  wire [`DMA_BEAT_W-1:0]     wdata,
    input  wire                       wlast,
    output logic                      bvalid,
    input  wire                       bready,
    output logic [1:0]                bresp,
    input  wire                       err_en,
    input  wire [`DMA_ADDR_W-1:0]     err_addr
);

    localparam int AW = `DMA_ADDR_W;

    logic [`DMA_BEAT_W-1:0] store [logic [`DMA_ADDR_W-1:0]];
    logic [`DMA_ADDR_W-1:0] aw_q [$];
    logic [`DMA_BEAT_W-1:0] w_q [$];
    int                     len_q [$];
    logic [1:0]             b_q [$];
    int                     beats_open;
    bit                     b_taken;

    function automatic bit holds(input logic [`DMA_ADDR_W-1:0] a);
        return store.exists(a) != 0;
    endfunction

    function automatic logic [`DMA_BEAT_W-1:0] peek(input logic [`DMA_ADDR_W-1:0] a);
        return store[a];
    endfunction

    // Data may arrive ahead of its address, so a burst lands once both sides are complete
    task automatic commit_bursts();
        logic [`DMA_ADDR_W-1:0] a;
        int                     beats;
        while ((aw_q.size() > 0) && (len_q.size() > 0)) begin
            a = aw_q.pop_front();
            beats = len_q.pop_front();
            for (int i = 0; i < beats; i++) begin
                store[a + AW'(16 * i)] = w_q.pop_front();
            end
            b_q.push_back((err_en && (a == err_addr)) ? 2'b10 : 2'b00);
        end
    endtask

    // Handshakes are sampled on the rising edge and outputs change on the falling edge
    initial begin
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = 2'b00;
        beats_open = 0;
        b_taken = 1'b0;
        forever begin
            @(posedge axi_out);
            b_taken = 1'b0;
            if (rst_n) begin
                if (awvalid && awready) begin
                    aw_q.push_back(awaddr);
                end
                if (wvalid && wready) begin
                    w_q.push_back(wdata);
                    beats_open++;
                    if (wlast) begin
                        len_q.push_back(beats_open);
                        beats_open = 0;
                    end
                end
                b_taken = bvalid && bready;
                if (b_taken) begin
                    void'(b_q.pop_front());
                end
                commit_bursts();
            end
            @(negedge axi_out);
            if (!rst_n) begin
                awready = 1'b0;
                wready = 1'b0;
                bvalid = 1'b0;
            end else begin
                awready = ($urandom % 100) >= STALL_PCT;
                wready = ($urandom % 100) >= STALL_PCT;
                if (b_taken) begin
                    bvalid = 1'b0;
                end
                if (!bvalid && (b_q.size() > 0) && (($urandom % 100) >= STALL_PCT)) begin
                    bvalid = 1'b1;
                    bresp = b_q[0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/capture_dma_top.sv ====
// Triggered capture DMA joining the capture buffer, beat packer and AXI burst writer
`default_nettype none
`include "dma_defines.svh"

module capture_dma_top (
    input  wire                         axi_out,
    input  wire                         rst_n,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire dma_pkg::sample_t       in_sample,
    input  wire                         trigger,
    input  wire [`DMA_BUF_AW:0]         packet_length,
    input  wire [`DMA_BUF_AW:0]         trigger_point,
    input  wire [`DMA_ADDR_W-1:0]       dma_base_addr,
    output logic                        awvalid,
    input  wire                         awready,
    output logic [`DMA_ADDR_W-1:0]      awaddr,
    output logic [7:0]                  awlen,
    output logic [2:0]                  awsize,
    output logic [1:0]                  awburst,
    output logic [`DMA_ID_W-1:0]        awid,
    output logic                        wvalid,
    input  wire                         wready,
    output logic [`DMA_BEAT_W-1:0]      wdata,
    output logic [`DMA_BEAT_W/8-1:0]    wstrb,
    output logic                        wlast,
    input  wire                         bvalid,
    output logic                        bready,
    input  wire [1:0]                   bresp,
    output logic                        dma_done,
    output logic                        dma_error
);

    import dma_pkg::*;

    logic    buf_valid;
    logic    buf_ready;
    sample_t buf_sample;
    logic    beat_valid;
    logic    beat_ready;
    beat_t   beat;

    capture_buffer u_buffer (
        .axi_out       (axi_out),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_sample     (in_sample),
        .trigger       (trigger),
        .packet_length (packet_length),
        .trigger_point (trigger_point),
        .drain_done    (dma_done),
        .buf_valid     (buf_valid),
        .buf_ready     (buf_ready),
        .buf_sample    (buf_sample)
    );

    beat_packer u_packer (
        .axi_out    (axi_out),
        .rst_n      (rst_n),
        .buf_valid  (buf_valid),
        .buf_ready  (buf_ready),
        .buf_sample (buf_sample),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat       (beat)
    );

    // The writer's completion pulse is both the external done and the buffer re-arm
    burst_writer u_writer (
        .axi_out       (axi_out),
        .rst_n         (rst_n),
        .beat_valid    (beat_valid),
        .beat_ready    (beat_ready),
        .beat          (beat),
        .dma_base_addr (dma_base_addr),
        .packet_length (packet_length),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .awlen         (awlen),
        .awsize        (awsize),
        .awburst       (awburst),
        .awid          (awid),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wlast         (wlast),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .drain_done    (dma_done),
        .dma_error     (dma_error)
    );

endmodule

`default_nettype wire

// ==== hdl/burst_writer.sv ====
// AXI4 burst write engine that stores beats as 16-beat INCR bursts and reports completion
`default_nettype none
`include "dma_defines.svh"

module burst_writer (
    input  wire                         axi_out,
    input  wire                         rst_n,
    input  wire                         beat_valid,
    output logic                        beat_ready,
    input  wire dma_pkg::beat_t         beat,
    input  wire [`DMA_ADDR_W-1:0]       dma_base_addr,
    input  wire [`DMA_BUF_AW:0]         packet_length,
    output logic                        awvalid,
    input  wire                         awready,
    output logic [`DMA_ADDR_W-1:0]      awaddr,
    output logic [7:0]                  awlen,
    output logic [2:0]                  awsize,
    output logic [1:0]                  awburst,
    output logic [`DMA_ID_W-1:0]        awid,
    output logic                        wvalid,
    input  wire                         wready,
    output logic [`DMA_BEAT_W-1:0]      wdata,
    output logic [`DMA_BEAT_W/8-1:0]    wstrb,
    output logic                        wlast,
    input  wire                         bvalid,
    output logic                        bready,
    input  wire [1:0]                   bresp,
    output logic                        drain_done,
    output logic                        dma_error
);

    import dma_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam int BEAT_BYTES  = `DMA_BEAT_W / 8;
    localparam int BURST_BYTES = BEAT_BYTES * `DMA_BURST_BEATS;
    localparam int BEAT_CW     = $clog2(`DMA_BURST_BEATS);
    // Samples per burst is a power of two, so the burst count is a shift
    localparam int BURST_SHIFT = $clog2(`DMA_BURST_BEATS * `DMA_BEAT_W / $bits(sample_t));

    wr_state_e              state;
    logic [`DMA_ADDR_W-1:0] addr_off;
    logic [BEAT_CW-1:0]     beat_cnt;
    logic [`DMA_BUF_AW:0]   burst_cnt;
    logic [`DMA_BUF_AW:0]   burst_total;
    logic                   w_done;
    logic                   w_phase;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   b_fire;
    aw_t                    aw_c;
    w_t                     w_c;
    b_t                     b_c;

    assign burst_total = packet_length >> BURST_SHIFT;

    assign aw_c.addr = dma_base_addr + addr_off;
    assign aw_c.len  = 8'(`DMA_BURST_BEATS - 1);
    assign w_c.data  = beat;
    assign w_c.last  = (beat_cnt == BEAT_CW'(`DMA_BURST_BEATS - 1));
    assign b_c.resp  = bresp;

    assign awaddr  = aw_c.addr;
    assign awlen   = aw_c.len;
    assign awsize  = 3'($clog2(BEAT_BYTES));
    assign awburst = 2'b01;
    assign awid    = '0;

    // Data may flow while the address is still waiting for awready
    assign w_phase    = ((state == WR_ADDR) || (state == WR_DATA)) && !w_done;
    assign wvalid     = w_phase && beat_valid;
    assign beat_ready = w_phase && wready;
    assign wdata      = w_c.data;
    assign wstrb      = '1;
    assign wlast      = w_c.last;

    assign bready     = (state == WR_RESP);
    assign drain_done = (state == WR_DONE);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    always_ff @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            state     <= WR_IDLE;
            awvalid   <= 1'b0;
            addr_off  <= '0;
            beat_cnt  <= '0;
            burst_cnt <= '0;
            w_done    <= 1'b0;
            dma_error <= 1'b0;
        end else begin
            if (w_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end

            case (state)
                WR_IDLE: begin
                    if (beat_valid) begin
                        state <= WR_ADDR;
                        // First burst of a new capture starts with a clean error flag
                        if (burst_cnt == '0) begin
                            dma_error <= 1'b0;
                        end
                    end
                end
                WR_ADDR: begin
                    if (!awvalid) begin
                        awvalid <= 1'b1;
                    end
                    if (w_fire && w_c.last) begin
                        w_done <= 1'b1;
                    end
                    if (aw_fire) begin
                        awvalid  <= 1'b0;
                        addr_off <= addr_off + BURST_BYTES;
                        if (w_done || (w_fire && w_c.last)) begin
                            state <= WR_RESP;
                        end else begin
                            state <= WR_DATA;
                        end
                    end
                end
                WR_DATA: begin
                    if (w_fire && w_c.last) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    w_done <= 1'b0;
                    if (b_fire) begin
                        if (b_c.resp != RESP_OKAY) begin
                            dma_error <= 1'b1;
                        end
                        if ((burst_cnt + 1'b1) == burst_total) begin
                            state <= WR_DONE;
                        end else begin
                            burst_cnt <= burst_cnt + 1'b1;
                            state     <= WR_IDLE;
                        end
                    end
                end
                WR_DONE: begin
                    // Next capture writes from the base address again
                    addr_off  <= '0;
                    burst_cnt <= '0;
                    state     <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/beat_packer.sv ====
// Sample pair packer that builds 128-bit beats and buffers them in a two-entry FIFO
`default_nettype none
`include "dma_defines.svh"

module beat_packer (
    input  wire                     axi_out,
    input  wire                     rst_n,
    input  wire                     buf_valid,
    output logic                    buf_ready,
    input  wire dma_pkg::sample_t   buf_sample,
    output logic                    beat_valid,
    input  wire                     beat_ready,
    output dma_pkg::beat_t          beat
);

    import dma_pkg::*;

    sample_t    lo_q;
    logic       half_q;
    beat_t      fifo [2];
    logic       wr_idx;
    logic       rd_idx;
    logic [1:0] count;
    logic       take;
    logic       push;
    logic       pop;

    // The first sample of a pair can always be held while the second needs FIFO room
    assign buf_ready  = !half_q || (count != 2'd2);
    assign take       = buf_valid && buf_ready;
    assign push       = take && half_q;
    assign pop        = beat_valid && beat_ready;

    assign beat_valid = (count != 2'd0);
    assign beat       = fifo[rd_idx];

    always_ff @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            half_q <= 1'b0;
            wr_idx <= 1'b0;
            rd_idx <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (take) begin
                half_q <= !half_q;
            end
            if (push) begin
                wr_idx <= !wr_idx;
            end
            if (pop) begin
                rd_idx <= !rd_idx;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge axi_out) begin
        if (take && !half_q) begin
            lo_q <= buf_sample;
        end
        if (push) begin
            fifo[wr_idx] <= '{hi: buf_sample, lo: lo_q};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/capture_buffer.sv ====
// Circular capture buffer that keeps a pre-trigger window and drains it in order
`default_nettype none
`include "dma_defines.svh"

module capture_buffer (
    input  wire                     axi_out,
    input  wire                     rst_n,
    input  wire                     in_valid,
    output logic                    in_ready,
    input  wire dma_pkg::sample_t   in_sample,
    input  wire                     trigger,
    input  wire [`DMA_BUF_AW:0]     packet_length,
    input  wire [`DMA_BUF_AW:0]     trigger_point,
    input  wire                     drain_done,
    output logic                    buf_valid,
    input  wire                     buf_ready,
    output dma_pkg::sample_t        buf_sample
);

    import dma_pkg::*;

    localparam int DEPTH = 1 << `DMA_BUF_AW;

    sample_t                mem [DEPTH];
    cap_state_e             state;
    cap_state_e             state_nxt;
    logic [`DMA_BUF_AW-1:0] wr_ptr;
    logic [`DMA_BUF_AW-1:0] rd_ptr;
    logic [`DMA_BUF_AW:0]   post_cnt;
    logic [`DMA_BUF_AW:0]   post_init;
    logic [`DMA_BUF_AW:0]   rd_left;
    logic                   accept;
    logic                   fire;
    logic                   load;

    assign accept = in_valid && in_ready;

    // Only a trigger seen while armed starts a window
    assign fire = accept && trigger && (state == CAP_ARMED);

    // Samples still expected after the trigger sample itself
    assign post_init = packet_length - trigger_point - 1'b1;

    // Fetch the next window sample whenever the output register is free or being taken
    assign load = (state == CAP_DRAIN) && (rd_left != '0) && (!buf_valid || buf_ready);

    always_comb begin
        state_nxt = state;
        case (state)
            CAP_ARMED: begin
                if (fire) begin
                    if (post_init == '0) begin
                        state_nxt = CAP_DRAIN;
                    end else begin
                        state_nxt = CAP_POST;
                    end
                end
            end
            CAP_POST: begin
                if (accept && (post_cnt == 1)) begin
                    state_nxt = CAP_DRAIN;
                end
            end
            CAP_DRAIN: begin
                // The writer signals when the whole window has reached memory
                if (drain_done) begin
                    state_nxt = CAP_ARMED;
                end
            end
            default: state_nxt = CAP_ARMED;
        endcase
    end

    always_ff @(posedge axi_out or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CAP_ARMED;
            in_ready  <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            post_cnt  <= '0;
            rd_left   <= '0;
            buf_valid <= 1'b0;
        end else begin
            state    <= state_nxt;
            // Registered so the input closes on the cycle after the last window sample
            in_ready <= (state_nxt != CAP_DRAIN);

            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (fire) begin
                // The window starts trigger_point samples before the trigger sample
                rd_ptr   <= wr_ptr - trigger_point[`DMA_BUF_AW-1:0];
                rd_left  <= packet_length;
                post_cnt <= post_init;
            end else if (accept && (state == CAP_POST)) begin
                post_cnt <= post_cnt - 1'b1;
            end

            if (load) begin
                rd_ptr    <= rd_ptr + 1'b1;
                rd_left   <= rd_left - 1'b1;
                buf_valid <= 1'b1;
            end else if (buf_ready) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // Sample memory and its registered read port
    always_ff @(posedge axi_out) begin
        if (accept) begin
            mem[wr_ptr] <= in_sample;
        end
        if (load) begin
            buf_sample <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dma_pkg.sv ====
// Shared types of the capture DMA for samples, beats, AXI channel payloads and FSM states
`default_nettype none
`include "dma_defines.svh"

package dma_pkg;

    // One stream sample with its tags and the user tag in the top bits
    typedef struct packed {
        logic [`DMA_TAG_W-1:0]  user;
        logic [`DMA_TAG_W-1:0]  dest;
        logic [`DMA_DATA_W-1:0] data;
    } sample_t;

    // The older sample of a pair goes in the low half
    typedef struct packed {
        sample_t hi;
        sample_t lo;
    } beat_t;

    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] addr;
        logic [7:0]             len;
    } aw_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } w_t;

    typedef struct packed {
        logic [1:0] resp;
    } b_t;

    typedef enum logic [1:0] {
        CAP_ARMED,
        CAP_POST,
        CAP_DRAIN
    } cap_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_DONE
    } wr_state_e;

endpackage

`default_nettype wire

// ==== hdl/dma_defines.svh ====
// Capture DMA width, depth and burst constants shared by the package and the RTL
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Stream sample payload width
`define DMA_DATA_W 32

// Width of each of the user and dest tags carried with a sample
`define DMA_TAG_W 16

// AXI write data width that holds two tagged samples per beat
`define DMA_BEAT_W 128

// AXI address width
`define DMA_ADDR_W 49

// AXI ID width
`define DMA_ID_W 2

// Capture buffer address width for a buffer of 1024 samples
`define DMA_BUF_AW 10

// Beats in every INCR burst
`define DMA_BURST_BEATS 16

`endif
